/* rtl/tile_cfg_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Tile configuration package
// Wishbone bus widths, register map offsets, control word fields
// and status word bit positions of the compute tile
//////////////////////////////////////////////////////////////////////

package tile_cfg_pkg;

  // Host bus
  localparam int unsigned WB_ADDR_W = 32;
  localparam int unsigned WB_DATA_W = 32;

  // Register map, word aligned
  localparam logic [WB_ADDR_W-1:0] REG_CTRL   = 32'h0;
  localparam logic [WB_ADDR_W-1:0] REG_OPND   = 32'h4;
  localparam logic [WB_ADDR_W-1:0] REG_RESULT = 32'h8;
  localparam logic [WB_ADDR_W-1:0] REG_STATUS = 32'hC;

  // Address bits that pick the register
  localparam int unsigned REG_SEL_LSB = 2;
  localparam int unsigned REG_SEL_W   = 2;

  // Control word fields
  localparam int unsigned CTRL_OP_LSB  = 0;
  localparam int unsigned CTRL_OP_W    = 2;
  localparam int unsigned CTRL_LEN_LSB = 8;
  localparam int unsigned CTRL_LEN_W   = 8;

  // Status word fields
  localparam int unsigned STAT_EVT_BIT    = 0;
  localparam int unsigned STAT_RVALID_BIT = 1;
  localparam int unsigned STAT_OFULL_BIT  = 2;
  localparam int unsigned STAT_CNT_LSB    = 8;

endpackage

/* rtl/hwpe_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Accelerator package
// Opcodes, operand and result widths, operand pair and result types
//////////////////////////////////////////////////////////////////////

package hwpe_pkg;

  localparam int unsigned OPERAND_W = 16;
  localparam int unsigned RESULT_W  = 32;

  // Job opcode, code 3 falls back to ADD
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_MUL = 2'd1,
    OP_MAC = 2'd2
  } opcode_e;

  // Operand b sits in the upper half of the written word
  typedef struct packed {
    logic [OPERAND_W-1:0] b;
    logic [OPERAND_W-1:0] a;
  } operand_pair_t;

  typedef logic [RESULT_W-1:0] result_t;

endpackage

/* rtl/hwpe_stream_fifo.sv */
//////////////////////////////////////////////////////////////////////
// Valid/ready FIFO with a generic payload type
// Circular buffer with occupancy count, push and pop in one cycle
//////////////////////////////////////////////////////////////////////

module hwpe_stream_fifo #(
  parameter int unsigned Depth     = 4,
  parameter type         payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  localparam int unsigned PTR_W = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CNT_W = $clog2(Depth + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(Depth - 1);

  payload_t         mem_q [Depth];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign in_ready_o  = (count_q != CNT_W'(Depth));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count holds when both sides move
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

/* rtl/hwpe_ctrl_decode.sv */
//////////////////////////////////////////////////////////////////////
// Wishbone classic slave of the tile
// Register decode, registered ack/err, operand push, job start
// and result pop
//////////////////////////////////////////////////////////////////////

module hwpe_ctrl_decode (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // Host port
  input  logic                                      wb_cyc_i,
  input  logic                                      wb_stb_i,
  input  logic                                      wb_we_i,
  input  logic [tile_cfg_pkg::WB_ADDR_W-1:0]        wb_adr_i,
  input  logic [tile_cfg_pkg::WB_DATA_W-1:0]        wb_dat_i,
  output logic [tile_cfg_pkg::WB_DATA_W-1:0]        wb_dat_o,
  output logic                                      wb_ack_o,
  output logic                                      wb_err_o,
  // Operand stream
  output logic                                      opnd_valid_o,
  input  logic                                      opnd_ready_i,
  output hwpe_pkg::operand_pair_t                   opnd_data_o,
  // Job control
  output logic                                      start_o,
  output hwpe_pkg::opcode_e                         opcode_o,
  output logic [tile_cfg_pkg::CTRL_LEN_W-1:0]       job_len_o,
  // Result side
  input  logic                                      res_valid_i,
  input  hwpe_pkg::result_t                         res_data_i,
  input  logic [tile_cfg_pkg::CTRL_LEN_W-1:0]       consumed_i,
  input  logic                                      evt_i,
  output logic                                      res_pop_o
);

  localparam logic [1:0] SEL_CTRL =
    2'(tile_cfg_pkg::REG_CTRL >> tile_cfg_pkg::REG_SEL_LSB);
  localparam logic [1:0] SEL_OPND =
    2'(tile_cfg_pkg::REG_OPND >> tile_cfg_pkg::REG_SEL_LSB);
  localparam logic [1:0] SEL_RESULT =
    2'(tile_cfg_pkg::REG_RESULT >> tile_cfg_pkg::REG_SEL_LSB);

  logic [tile_cfg_pkg::REG_SEL_W-1:0] reg_sel;
  logic                               req;
  logic [tile_cfg_pkg::WB_DATA_W-1:0] ctrl_q;
  logic [tile_cfg_pkg::WB_DATA_W-1:0] status_word;
  logic [tile_cfg_pkg::WB_DATA_W-1:0] rdata_d;
  logic                               ack_d;
  logic                               err_d;

  // New access only while no response is on the bus
  assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;
  assign reg_sel = wb_adr_i[tile_cfg_pkg::REG_SEL_LSB +: tile_cfg_pkg::REG_SEL_W];

  // Operand push is held by the host until the FIFO takes it
  assign opnd_valid_o = req & wb_we_i & (reg_sel == SEL_OPND);
  assign opnd_data_o  = hwpe_pkg::operand_pair_t'(wb_dat_i);

  assign res_pop_o = req & ~wb_we_i & (reg_sel == SEL_RESULT) & res_valid_i;

  assign opcode_o  = hwpe_pkg::opcode_e'(
    ctrl_q[tile_cfg_pkg::CTRL_OP_LSB +: tile_cfg_pkg::CTRL_OP_W]);
  assign job_len_o = ctrl_q[tile_cfg_pkg::CTRL_LEN_LSB +: tile_cfg_pkg::CTRL_LEN_W];

  always_comb begin
    status_word = '0;
    status_word[tile_cfg_pkg::STAT_EVT_BIT]    = evt_i;
    status_word[tile_cfg_pkg::STAT_RVALID_BIT] = res_valid_i;
    status_word[tile_cfg_pkg::STAT_OFULL_BIT]  = ~opnd_ready_i;
    status_word[tile_cfg_pkg::STAT_CNT_LSB +: tile_cfg_pkg::CTRL_LEN_W] = consumed_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Response select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ack_d   = 1'b0;
    err_d   = 1'b0;
    rdata_d = '0;
    if (req) begin
      case (reg_sel)
        SEL_CTRL: begin
          ack_d   = 1'b1;
          rdata_d = ctrl_q;
        end
        SEL_OPND: begin
          // Writes wait for room in the operand FIFO
          ack_d = ~wb_we_i | opnd_ready_i;
        end
        SEL_RESULT: begin
          if (wb_we_i || res_valid_i) begin
            ack_d   = 1'b1;
            rdata_d = res_data_i;
          end else begin
            err_d = 1'b1;
          end
        end
        default: begin
          ack_d   = 1'b1;
          rdata_d = status_word;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      start_o  <= 1'b0;
      ctrl_q   <= '0;
    end else begin
      wb_ack_o <= ack_d;
      wb_err_o <= err_d;
      start_o  <= req & wb_we_i & (reg_sel == SEL_CTRL);
      if (req && wb_we_i && (reg_sel == SEL_CTRL)) begin
        ctrl_q <= wb_dat_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    wb_dat_o <= rdata_d;
  end

endmodule

/* rtl/hwpe_mac_engine.sv */
//////////////////////////////////////////////////////////////////////
// Execute stage of the tile
// ADD, MUL and MAC on operand pairs with a one deep output register
//////////////////////////////////////////////////////////////////////

module hwpe_mac_engine (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Job control
  input  logic                    start_i,
  input  hwpe_pkg::opcode_e       opcode_i,
  // Operand stream in
  input  logic                    opnd_valid_i,
  output logic                    opnd_ready_o,
  input  hwpe_pkg::operand_pair_t opnd_data_i,
  // Result stream out
  output logic                    res_valid_o,
  input  logic                    res_ready_i,
  output hwpe_pkg::result_t       res_data_o
);

  hwpe_pkg::opcode_e op_q;
  hwpe_pkg::result_t acc_q;
  hwpe_pkg::result_t res_q;
  hwpe_pkg::result_t sum;
  hwpe_pkg::result_t prod;
  hwpe_pkg::result_t mac;
  hwpe_pkg::result_t res_d;
  logic              valid_q;
  logic              fire;

  // Take a pair when the output stage is empty or draining
  assign opnd_ready_o = ~valid_q | res_ready_i;
  assign fire         = opnd_valid_i & opnd_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  assign sum  = hwpe_pkg::result_t'(opnd_data_i.a) + hwpe_pkg::result_t'(opnd_data_i.b);
  assign prod = hwpe_pkg::result_t'(opnd_data_i.a) * hwpe_pkg::result_t'(opnd_data_i.b);
  // Wraps modulo 2^32
  assign mac  = acc_q + prod;

  always_comb begin
    case (op_q)
      hwpe_pkg::OP_MUL: res_d = prod;
      hwpe_pkg::OP_MAC: res_d = mac;
      default:          res_d = sum;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_q    <= hwpe_pkg::OP_ADD;
      acc_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      if (start_i) begin
        op_q  <= opcode_i;
        acc_q <= '0;
      end else if (fire && (op_q == hwpe_pkg::OP_MAC)) begin
        acc_q <= mac;
      end
      if (fire) begin
        valid_q <= 1'b1;
      end else if (res_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Output held while the result FIFO stalls
  always_ff @(posedge clk_i) begin
    if (fire) begin
      res_q <= res_d;
    end
  end

  assign res_valid_o = valid_q;
  assign res_data_o  = res_q;

endmodule

/* rtl/hwpe_result_unit.sv */
//////////////////////////////////////////////////////////////////////
// Result stage of the tile
// Head holding register, consumed count and sticky job event
//////////////////////////////////////////////////////////////////////

module hwpe_result_unit (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Job control
  input  logic                                start_i,
  input  logic [tile_cfg_pkg::CTRL_LEN_W-1:0] job_len_i,
  // Result stream in
  input  logic                                res_valid_i,
  output logic                                res_ready_o,
  input  hwpe_pkg::result_t                   res_data_i,
  // Host side
  input  logic                                pop_i,
  output logic                                head_valid_o,
  output hwpe_pkg::result_t                   head_data_o,
  output logic [tile_cfg_pkg::CTRL_LEN_W-1:0] consumed_o,
  output logic                                evt_o
);

  logic [tile_cfg_pkg::CTRL_LEN_W-1:0] len_q;
  logic [tile_cfg_pkg::CTRL_LEN_W-1:0] count_q;
  logic [tile_cfg_pkg::CTRL_LEN_W-1:0] count_inc;
  hwpe_pkg::result_t                   head_q;
  logic                                head_valid_q;
  logic                                evt_q;
  logic                                load;

  // Refill in the same cycle as a pop
  assign res_ready_o = ~head_valid_q | pop_i;
  assign load        = res_valid_i & res_ready_o;
  assign count_inc   = count_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_valid_q <= 1'b0;
      len_q        <= '0;
      count_q      <= '0;
      evt_q        <= 1'b0;
    end else begin
      if (load) begin
        head_valid_q <= 1'b1;
      end else if (pop_i) begin
        head_valid_q <= 1'b0;
      end
      if (start_i) begin
        len_q   <= job_len_i;
        count_q <= '0;
        evt_q   <= 1'b0;
      end else if (pop_i) begin
        count_q <= count_inc;
        // Sticky until the next start
        if ((count_inc == len_q) && (len_q != '0)) begin
          evt_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      head_q <= res_data_i;
    end
  end

  assign head_valid_o = head_valid_q;
  assign head_data_o  = head_q;
  assign consumed_o   = count_q;
  assign evt_o        = evt_q;

endmodule

/* rtl/cluster_hwpe_tile.sv */
//////////////////////////////////////////////////////////////////////
// Compute tile top level
// Wishbone decode, operand FIFO, MAC engine, result FIFO and
// result unit
//////////////////////////////////////////////////////////////////////

module cluster_hwpe_tile #(
  parameter int unsigned OpndDepth = 4,
  parameter int unsigned ResDepth  = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [tile_cfg_pkg::WB_ADDR_W-1:0] wb_adr_i,
  input  logic [tile_cfg_pkg::WB_DATA_W-1:0] wb_dat_i,
  output logic [tile_cfg_pkg::WB_DATA_W-1:0] wb_dat_o,
  output logic                               wb_ack_o,
  output logic                               wb_err_o,
  output logic                               evt_o
);

  logic                                opnd_valid;
  logic                                opnd_ready;
  hwpe_pkg::operand_pair_t             opnd_data;
  logic                                eng_in_valid;
  logic                                eng_in_ready;
  hwpe_pkg::operand_pair_t             eng_in_data;
  logic                                eng_out_valid;
  logic                                eng_out_ready;
  hwpe_pkg::result_t                   eng_out_data;
  logic                                rf_valid;
  logic                                rf_ready;
  hwpe_pkg::result_t                   rf_data;
  logic                                head_valid;
  hwpe_pkg::result_t                   head_data;
  logic [tile_cfg_pkg::CTRL_LEN_W-1:0] consumed;
  logic [tile_cfg_pkg::CTRL_LEN_W-1:0] job_len;
  hwpe_pkg::opcode_e                   opcode;
  logic                                start;
  logic                                res_pop;

  hwpe_ctrl_decode i_decode (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .opnd_valid_o (opnd_valid),
    .opnd_ready_i (opnd_ready),
    .opnd_data_o  (opnd_data),
    .start_o      (start),
    .opcode_o     (opcode),
    .job_len_o    (job_len),
    .res_valid_i  (head_valid),
    .res_data_i   (head_data),
    .consumed_i   (consumed),
    .evt_i        (evt_o),
    .res_pop_o    (res_pop)
  );

  hwpe_stream_fifo #(
    .Depth    (OpndDepth),
    .payload_t(hwpe_pkg::operand_pair_t)
  ) i_opnd_fifo (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (opnd_valid),
    .in_ready_o (opnd_ready),
    .in_data_i  (opnd_data),
    .out_valid_o(eng_in_valid),
    .out_ready_i(eng_in_ready),
    .out_data_o (eng_in_data)
  );

  hwpe_mac_engine i_engine (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (start),
    .opcode_i    (opcode),
    .opnd_valid_i(eng_in_valid),
    .opnd_ready_o(eng_in_ready),
    .opnd_data_i (eng_in_data),
    .res_valid_o (eng_out_valid),
    .res_ready_i (eng_out_ready),
    .res_data_o  (eng_out_data)
  );

  hwpe_stream_fifo #(
    .Depth    (ResDepth),
    .payload_t(hwpe_pkg::result_t)
  ) i_res_fifo (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (eng_out_valid),
    .in_ready_o (eng_out_ready),
    .in_data_i  (eng_out_data),
    .out_valid_o(rf_valid),
    .out_ready_i(rf_ready),
    .out_data_o (rf_data)
  );

  hwpe_result_unit i_result (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (start),
    .job_len_i   (job_len),
    .res_valid_i (rf_valid),
    .res_ready_o (rf_ready),
    .res_data_i  (rf_data),
    .pop_i       (res_pop),
    .head_valid_o(head_valid),
    .head_data_o (head_data),
    .consumed_o  (consumed),
    .evt_o       (evt_o)
  );

endmodule

/* verification/tb_clock_gen.sv */
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset source
//////////////////////////////////////////////////////////////////////

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* verification/tb_cluster_hwpe_tile.sv */
//////////////////////////////////////////////////////////////////////
// Testbench of the compute tile
// Wishbone host tasks, reference model, assertions and timeout
//////////////////////////////////////////////////////////////////////

module tb_cluster_hwpe_tile;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned OPND_DEPTH = 4;
  localparam int unsigned RES_DEPTH  = 4;
  localparam int unsigned RAND_SEED  = 59679;
  // Both FIFOs, the engine stage and the holding register
  localparam int unsigned BP_PAIRS   = OPND_DEPTH + RES_DEPTH + 2;
  // About 150 bus accesses of at most 20 cycles each
  localparam int unsigned MAX_ACCESSES   = 150;
  localparam int unsigned ACCESS_CYCLES  = 20;
  localparam int unsigned TIMEOUT_CYCLES = MAX_ACCESSES * ACCESS_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  logic        evt;
  logic [31:0] expected_q [$];
  logic [31:0] acc_model;
  logic [31:0] rdata;
  logic [31:0] status_exp;
  logic [31:0] status_before;
  logic        got_err;
  int unsigned cycle_cnt = 0;

  tb_clock_gen #(
    .PeriodNs   (40),
    .ResetCycles(8)
  ) i_clock_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  cluster_hwpe_tile #(
    .OpndDepth(OPND_DEPTH),
    .ResDepth (RES_DEPTH)
  ) i_dut (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .wb_cyc_i(wb_cyc),
    .wb_stb_i(wb_stb),
    .wb_we_i (wb_we),
    .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat_w),
    .wb_dat_o(wb_dat_r),
    .wb_ack_o(wb_ack),
    .wb_err_o(wb_err),
    .evt_o   (evt)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string test_name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val)
    else report_failure($sformatf("CHECK FAILED %s expected 0x%08h actual 0x%08h",
                                  test_name, exp_val, act_val));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus protocol checks
  //////////////////////////////////////////////////////////////////////

  ack_err_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(wb_ack && wb_err))
  else report_failure("The tile raised ack and err in the same cycle");

  response_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ack || wb_err) |=> !(wb_ack || wb_err))
  else report_failure("A bus response lasted longer than one cycle");

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure("Timeout: the run went past its cycle limit without finishing");
    end
  end

  // One access driven on the falling edge and held until ack or err
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                            output logic [31:0] resp_data, output logic resp_err);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
      @(negedge clk);
    end while (!wb_ack && !wb_err);
    resp_data = wb_dat_r;
    resp_err  = wb_err;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
  endtask

  task automatic write_reg(input logic [31:0] adr, input logic [31:0] data);
    logic [31:0] ignored_data;
    logic        resp_err;
    bus_access(1'b1, adr, data, ignored_data, resp_err);
    assert (!resp_err)
    else report_failure($sformatf("Write to 0x%0h got err instead of ack", adr));
  endtask

  task automatic read_reg(input logic [31:0] adr, output logic [31:0] data);
    logic resp_err;
    bus_access(1'b0, adr, 32'd0, data, resp_err);
    assert (!resp_err)
    else report_failure($sformatf("Read of 0x%0h got err instead of ack", adr));
  endtask

  task automatic start_job(input hwpe_pkg::opcode_e op, input logic [7:0] len);
    logic [31:0] ctrl;
    logic [31:0] status;
    ctrl = '0;
    ctrl[tile_cfg_pkg::CTRL_OP_LSB +: tile_cfg_pkg::CTRL_OP_W]   = op;
    ctrl[tile_cfg_pkg::CTRL_LEN_LSB +: tile_cfg_pkg::CTRL_LEN_W] = len;
    write_reg(tile_cfg_pkg::REG_CTRL, ctrl);
    acc_model = '0;
    read_reg(tile_cfg_pkg::REG_CTRL, status);
    check_value("ctrl_readback", ctrl, status);
    // Start clears the event and the consumed count
    read_reg(tile_cfg_pkg::REG_STATUS, status);
    check_value("start_clears_status", 32'd0, status);
    check_value("start_clears_evt", 32'd0, 32'(evt));
  endtask

  // Reference model per opcode rule
  task automatic push_pair(input hwpe_pkg::opcode_e op);
    logic [15:0] a;
    logic [15:0] b;
    logic [31:0] prod;
    a    = 16'($urandom());
    b    = 16'($urandom());
    prod = {16'd0, a} * {16'd0, b};
    case (op)
      hwpe_pkg::OP_MUL: expected_q.push_back(prod);
      hwpe_pkg::OP_MAC: begin
        acc_model = acc_model + prod;
        expected_q.push_back(acc_model);
      end
      default: expected_q.push_back({16'd0, a} + {16'd0, b});
    endcase
    write_reg(tile_cfg_pkg::REG_OPND, {b, a});
  endtask

  task automatic pop_result(input string test_name, input int unsigned reads_done);
    logic [31:0] status;
    logic [31:0] result;
    do begin
      read_reg(tile_cfg_pkg::REG_STATUS, status);
    end while (!status[tile_cfg_pkg::STAT_RVALID_BIT]);
    check_value({test_name, "_consumed"}, reads_done,
                32'(status[tile_cfg_pkg::STAT_CNT_LSB +: tile_cfg_pkg::CTRL_LEN_W]));
    check_value({test_name, "_evt_bit_low"}, 32'd0,
                32'(status[tile_cfg_pkg::STAT_EVT_BIT]));
    check_value({test_name, "_evt_low"}, 32'd0, 32'(evt));
    read_reg(tile_cfg_pkg::REG_RESULT, result);
    check_value($sformatf("%s_result_%0d", test_name, reads_done),
                expected_q.pop_front(), result);
  endtask

  task automatic drain_job(input string test_name, input int unsigned len);
    logic [31:0] status;
    for (int unsigned i = 0; i < len; i++) begin
      pop_result(test_name, i);
    end
    read_reg(tile_cfg_pkg::REG_STATUS, status);
    check_value({test_name, "_final_status"},
                (len << tile_cfg_pkg::STAT_CNT_LSB) | (32'd1 << tile_cfg_pkg::STAT_EVT_BIT),
                status);
    check_value({test_name, "_evt_high"}, 32'd1, 32'(evt));
  endtask

  task automatic run_job(input string test_name, input hwpe_pkg::opcode_e op,
                         input int unsigned len);
    start_job(op, 8'(len));
    repeat (len) push_pair(op);
    drain_job(test_name, len);
  endtask

  initial begin
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    acc_model = '0;
    void'($urandom(RAND_SEED));
    @(posedge rst_n);
    @(negedge clk);
    check_value("reset_ack", 32'd0, 32'(wb_ack));
    check_value("reset_err", 32'd0, 32'(wb_err));
    check_value("reset_evt", 32'd0, 32'(evt));
    read_reg(tile_cfg_pkg::REG_STATUS, rdata);
    check_value("reset_status", 32'd0, rdata);
    read_reg(tile_cfg_pkg::REG_CTRL, rdata);
    check_value("reset_ctrl", 32'd0, rdata);

    run_job("add", hwpe_pkg::OP_ADD, 6);
    run_job("mul", hwpe_pkg::OP_MUL, 6);
    run_job("mac", hwpe_pkg::OP_MAC, 8);
    // Second MAC job sums from zero again
    run_job("mac_restart", hwpe_pkg::OP_MAC, 3);

    // Fill every stage without reading
    start_job(hwpe_pkg::OP_MUL, 8'(BP_PAIRS));
    repeat (BP_PAIRS) push_pair(hwpe_pkg::OP_MUL);
    status_exp = '0;
    status_exp[tile_cfg_pkg::STAT_OFULL_BIT]  = 1'b1;
    status_exp[tile_cfg_pkg::STAT_RVALID_BIT] = 1'b1;
    read_reg(tile_cfg_pkg::REG_STATUS, rdata);
    check_value("backpressure_status", status_exp, rdata);
    drain_job("backpressure", BP_PAIRS);

    // Empty result register
    read_reg(tile_cfg_pkg::REG_STATUS, status_before);
    bus_access(1'b0, tile_cfg_pkg::REG_RESULT, 32'd0, rdata, got_err);
    check_value("empty_read_err", 32'd1, 32'(got_err));
    check_value("empty_read_data", 32'd0, rdata);
    read_reg(tile_cfg_pkg::REG_STATUS, rdata);
    check_value("empty_read_status", status_before, rdata);

    $display("All tests passed");
    $finish;
  end

endmodule

/* cluster_hwpe_tile.f */
rtl/tile_cfg_pkg.sv
rtl/hwpe_pkg.sv
rtl/hwpe_stream_fifo.sv
rtl/hwpe_ctrl_decode.sv
rtl/hwpe_mac_engine.sv
rtl/hwpe_result_unit.sv
rtl/cluster_hwpe_tile.sv
verification/tb_clock_gen.sv
verification/tb_cluster_hwpe_tile.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_cluster_hwpe_tile
FILELIST  := cluster_hwpe_tile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
